/* hw/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 8

// on-chip RAM, 64 words
`define SOC_MEM_AW 6

// word address of the trap control register
`define SOC_TRAP_ADDR 255

// clock cycles per UART bit
`define SOC_UART_DIV 8

// internal reset stretch after reset_i falls
`define SOC_RST_HOLD 16

// host protocol bytes
`define SOC_CMD_WRITE 8'h57
`define SOC_CMD_READ 8'h52
`define SOC_RSP_ACK 8'h4B

`endif

/* hw/soc_pkg.sv */
`default_nettype none

`include "soc_params.svh"

package soc_pkg;

   typedef logic [`SOC_DATA_W-1:0] soc_data_t;
   typedef logic [`SOC_ADDR_W-1:0] soc_addr_t;
   typedef logic [7:0] soc_byte_t;

   // byte with a valid flag, used for both UART directions
   typedef struct packed {
      logic valid;
      soc_byte_t data;
   } byte_strm_t;

   // wishbone classic, master to slave
   typedef struct packed {
      logic cyc;
      logic stb;
      logic we;
      soc_addr_t adr;
      soc_data_t dat;
   } wb_m2s_t;

   // wishbone classic, slave to master
   typedef struct packed {
      logic ack;
      soc_data_t dat;
   } wb_s2m_t;

   typedef enum logic [2:0] {IDLE, ADDR, WDATA, BUS, RESP} bridge_state_t;

endpackage

`default_nettype wire

/* hw/reset_pulse_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module reset_pulse_gen (
   input  logic clk_i,
   input  logic reset_i,
   output logic rst_o
);

   localparam int CNT_W = $clog2(`SOC_RST_HOLD + 1);

   logic [CNT_W-1:0] hold_cnt;
   logic rst_q;
   logic hold_busy;

   // counter still running after reset_i went low
   assign hold_busy = (hold_cnt != '0);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         // reload while the board reset is asserted
         hold_cnt <= CNT_W'(`SOC_RST_HOLD);
         rst_q <= 1'b1;
      end else begin
         if (hold_busy) begin
            hold_cnt <= hold_cnt - 1'b1;
         end
         rst_q <= hold_busy;
      end
   end

   assign rst_o = rst_q;

endmodule

`default_nettype wire

/* hw/uart_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module uart_core (
   input  logic clk_i,
   input  logic reset_i,
   input  logic rxd_i,
   output logic txd_o,
   output soc_pkg::byte_strm_t rx_o,
   input  soc_pkg::byte_strm_t tx_i,
   output logic tx_ready_o
);

   localparam int DIV_W = $clog2(`SOC_UART_DIV);
   localparam logic [DIV_W-1:0] DIV_FULL = DIV_W'(`SOC_UART_DIV - 1);
   localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(`SOC_UART_DIV / 2 - 1);

   // receiver
   logic rx_meta;
   logic rx_s;
   logic rx_busy;
   logic [DIV_W-1:0] rx_div;
   logic [3:0] rx_bit;
   soc_pkg::soc_byte_t rx_shift;
   logic rx_valid;
   soc_pkg::soc_byte_t rx_data;

   // transmitter
   logic tx_busy;
   logic [DIV_W-1:0] tx_div;
   logic [3:0] tx_bit;
   logic [8:0] tx_shift;
   logic tx_line;

   // two-flop synchronizer, idle line is high
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rx_meta <= 1'b1;
         rx_s <= 1'b1;
      end else begin
         rx_meta <= rxd_i;
         rx_s <= rx_meta;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rx_busy <= 1'b0;
         rx_valid <= 1'b0;
         rx_div <= '0;
         rx_bit <= '0;
      end else begin
         rx_valid <= 1'b0;
         if (!rx_busy) begin
            if (!rx_s) begin
               // start edge, first sample lands mid start bit
               rx_busy <= 1'b1;
               rx_div <= DIV_HALF;
               rx_bit <= '0;
            end
         end else if (rx_div != '0) begin
            rx_div <= rx_div - 1'b1;
         end else begin
            rx_div <= DIV_FULL;
            if (rx_bit == 4'd0) begin
               // glitch, line back high at mid start bit
               if (rx_s) begin
                  rx_busy <= 1'b0;
               end
               rx_bit <= 4'd1;
            end else if (rx_bit != 4'd9) begin
               rx_bit <= rx_bit + 1'b1;
            end else begin
               rx_busy <= 1'b0;
               // bad stop bit drops the frame
               rx_valid <= rx_s;
            end
         end
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk_i) begin
      if (rx_busy && rx_div == '0 && rx_bit != 4'd0 && rx_bit != 4'd9) begin
         rx_shift <= {rx_s, rx_shift[7:1]};
      end
      if (rx_busy && rx_div == '0 && rx_bit == 4'd9) begin
         rx_data <= rx_shift;
      end
   end

   assign rx_o.valid = rx_valid;
   assign rx_o.data = rx_data;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         tx_busy <= 1'b0;
         tx_line <= 1'b1;
         tx_div <= '0;
         tx_bit <= '0;
      end else if (!tx_busy) begin
         if (tx_i.valid) begin
            // start bit goes out right away
            tx_busy <= 1'b1;
            tx_line <= 1'b0;
            tx_div <= DIV_FULL;
            tx_bit <= '0;
         end
      end else if (tx_div != '0) begin
         tx_div <= tx_div - 1'b1;
      end else if (tx_bit == 4'd9) begin
         // end of stop bit
         tx_busy <= 1'b0;
      end else begin
         tx_line <= tx_shift[0];
         tx_div <= DIV_FULL;
         tx_bit <= tx_bit + 1'b1;
      end
   end

   // data bits then stop bit, shifted lsb first
   always_ff @(posedge clk_i) begin
      if (!tx_busy && tx_i.valid) begin
         tx_shift <= {1'b1, tx_i.data};
      end else if (tx_busy && tx_div == '0 && tx_bit != 4'd9) begin
         tx_shift <= {1'b1, tx_shift[8:1]};
      end
   end

   assign txd_o = tx_line;
   assign tx_ready_o = !tx_busy;

endmodule

`default_nettype wire

/* hw/uart_wb_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module uart_wb_bridge (
   input  logic clk_i,
   input  logic reset_i,
   input  soc_pkg::byte_strm_t rx_i,
   output soc_pkg::byte_strm_t tx_o,
   input  logic tx_ready_i,
   output soc_pkg::wb_m2s_t wb_o,
   input  soc_pkg::wb_s2m_t wb_i
);

   soc_pkg::bridge_state_t state;
   logic is_write;
   soc_pkg::soc_addr_t addr;
   soc_pkg::soc_data_t wdata;
   soc_pkg::soc_data_t rdata;
   logic [1:0] byte_cnt;
   logic bus_req;
   logic tx_valid;
   logic tx_take;

   assign tx_take = tx_valid && tx_ready_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state <= soc_pkg::IDLE;
         bus_req <= 1'b0;
         tx_valid <= 1'b0;
         byte_cnt <= '0;
      end else begin
         case (state)
            soc_pkg::IDLE: begin
               // unknown command bytes are dropped here
               if (rx_i.valid && (rx_i.data == `SOC_CMD_WRITE ||
                                  rx_i.data == `SOC_CMD_READ)) begin
                  state <= soc_pkg::ADDR;
               end
            end
            soc_pkg::ADDR: begin
               if (rx_i.valid) begin
                  byte_cnt <= '0;
                  if (is_write) begin
                     state <= soc_pkg::WDATA;
                  end else begin
                     state <= soc_pkg::BUS;
                     bus_req <= 1'b1;
                  end
               end
            end
            soc_pkg::WDATA: begin
               if (rx_i.valid) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == 2'd3) begin
                     state <= soc_pkg::BUS;
                     bus_req <= 1'b1;
                  end
               end
            end
            soc_pkg::BUS: begin
               // cyc and stb drop in the cycle after ack
               if (wb_i.ack) begin
                  bus_req <= 1'b0;
                  tx_valid <= 1'b1;
                  byte_cnt <= '0;
                  state <= soc_pkg::RESP;
               end
            end
            soc_pkg::RESP: begin
               if (tx_take) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (is_write || byte_cnt == 2'd3) begin
                     tx_valid <= 1'b0;
                     state <= soc_pkg::IDLE;
                  end
               end
            end
            default: begin
               state <= soc_pkg::IDLE;
            end
         endcase
      end
   end

   // payload registers
   always_ff @(posedge clk_i) begin
      if (state == soc_pkg::IDLE && rx_i.valid) begin
         is_write <= (rx_i.data == `SOC_CMD_WRITE);
      end
      if (state == soc_pkg::ADDR && rx_i.valid) begin
         addr <= rx_i.data;
      end
      // lsb first, so each byte enters at the top
      if (state == soc_pkg::WDATA && rx_i.valid) begin
         wdata <= {rx_i.data, wdata[`SOC_DATA_W-1:8]};
      end
      if (state == soc_pkg::BUS && wb_i.ack) begin
         rdata <= wb_i.dat;
      end else if (state == soc_pkg::RESP && tx_take) begin
         rdata <= rdata >> 8;
      end
   end

   assign tx_o.valid = tx_valid;
   assign tx_o.data = is_write ? `SOC_RSP_ACK : rdata[7:0];

   // adr, we and dat stay put for the whole bus cycle
   assign wb_o.cyc = bus_req;
   assign wb_o.stb = bus_req;
   assign wb_o.we = is_write;
   assign wb_o.adr = addr;
   assign wb_o.dat = wdata;

endmodule

`default_nettype wire

/* hw/soc_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module soc_mem (
   input  logic clk_i,
   input  logic reset_i,
   input  soc_pkg::wb_m2s_t wb_i,
   output soc_pkg::wb_s2m_t wb_o,
   output logic trap_o
);

   localparam int MEM_DEPTH = 1 << `SOC_MEM_AW;

   soc_pkg::soc_data_t ram [MEM_DEPTH];
   soc_pkg::soc_data_t rd_data;
   logic ack_q;
   logic trap_q;
   logic access;
   logic ram_sel;
   logic trap_sel;

   // new request, only once per cycle
   assign access = wb_i.cyc && wb_i.stb && !ack_q;

   // address decode
   assign ram_sel = (wb_i.adr[`SOC_ADDR_W-1:`SOC_MEM_AW] == '0);
   assign trap_sel = (wb_i.adr == soc_pkg::soc_addr_t'(`SOC_TRAP_ADDR));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         trap_q <= 1'b0;
      end else begin
         ack_q <= access;
         if (access && wb_i.we && trap_sel) begin
            trap_q <= wb_i.dat[0];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (access && wb_i.we && ram_sel) begin
         ram[wb_i.adr[`SOC_MEM_AW-1:0]] <= wb_i.dat;
      end
      if (access) begin
         if (ram_sel) begin
            rd_data <= ram[wb_i.adr[`SOC_MEM_AW-1:0]];
         end else if (trap_sel) begin
            rd_data <= {{(`SOC_DATA_W-1){1'b0}}, trap_q};
         end else begin
            // unmapped, reads as zero
            rd_data <= '0;
         end
      end
   end

   assign wb_o.ack = ack_q;
   assign wb_o.dat = rd_data;
   assign trap_o = trap_q;

endmodule

`default_nettype wire

/* hw/soc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_top (
   input  logic clk_i,
   input  logic reset_i,
   input  logic rxd_i,
   output logic txd_o,
   output logic trap_o
);

   logic soc_rst;
   logic tx_ready;
   soc_pkg::byte_strm_t rx_strm;
   soc_pkg::byte_strm_t tx_strm;
   soc_pkg::wb_m2s_t wb_m2s;
   soc_pkg::wb_s2m_t wb_s2m;

   // stretched internal reset
   reset_pulse_gen reset_pulse0 (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .rst_o  (soc_rst)
   );

   uart_core uart0 (
      .clk_i     (clk_i),
      .reset_i   (soc_rst),
      .rxd_i     (rxd_i),
      .txd_o     (txd_o),
      .rx_o      (rx_strm),
      .tx_i      (tx_strm),
      .tx_ready_o(tx_ready)
   );

   // host bridge, only bus master
   uart_wb_bridge bridge0 (
      .clk_i     (clk_i),
      .reset_i   (soc_rst),
      .rx_i      (rx_strm),
      .tx_o      (tx_strm),
      .tx_ready_i(tx_ready),
      .wb_o      (wb_m2s),
      .wb_i      (wb_s2m)
   );

   soc_mem mem0 (
      .clk_i  (clk_i),
      .reset_i(soc_rst),
      .wb_i   (wb_m2s),
      .wb_o   (wb_s2m),
      .trap_o (trap_o)
   );

endmodule

`default_nettype wire

/* verif/tb_soc_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module tb_soc_top;

   localparam int BYTE_CYCLES = 10 * `SOC_UART_DIV;
   // response start is a few cycles after the last frame byte
   localparam int RX_LIMIT = 4 * BYTE_CYCLES;
   // about 300 frames of at most 7 bytes at 80 cycles each, plus the idle window and margin
   localparam int MAX_CYCLES = 250000;

   logic clk_i;
   logic reset_i;
   logic rxd_i;
   logic txd_o;
   logic trap_o;

   integer seed;
   int cycle_cnt;
   int test_errs;
   int total_errs;
   int tests_run;
   int tests_failed;

   // reference model of the RAM and the trap bit
   soc_pkg::soc_data_t mem_model [64];
   logic mem_valid [64];
   logic trap_model;

   soc_top dut0 (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .rxd_i  (rxd_i),
      .txd_o  (txd_o),
      .trap_o (trap_o)
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic check_word(input string name, input soc_pkg::soc_data_t expected,
                             input soc_pkg::soc_data_t actual);
      assert (actual === expected) else begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         test_errs++;
      end
   endtask

   // 8N1 frame on rxd_i, called on a falling edge
   task automatic send_byte(input soc_pkg::soc_byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         rxd_i = frame[i];
         repeat (`SOC_UART_DIV) @(negedge clk_i);
      end
   endtask

   task automatic recv_byte(input string name, output soc_pkg::soc_byte_t b,
                            output logic got);
      int wait_cnt;
      wait_cnt = 0;
      got = 1'b0;
      b = '0;
      while (txd_o !== 1'b0 && wait_cnt < RX_LIMIT) begin
         @(negedge clk_i);
         wait_cnt++;
      end
      got = (txd_o === 1'b0);
      assert (got) else begin
         $display("%s: no start bit on txd_o within %0d cycles", name, RX_LIMIT);
         test_errs++;
      end
      if (got) begin
         // middle of the start bit
         repeat (`SOC_UART_DIV / 2) @(negedge clk_i);
         for (int i = 0; i < 8; i++) begin
            repeat (`SOC_UART_DIV) @(negedge clk_i);
            b[i] = txd_o;
         end
         repeat (`SOC_UART_DIV) @(negedge clk_i);
         assert (txd_o === 1'b1) else begin
            $display("%s: stop bit on txd_o was not high", name);
            test_errs++;
         end
      end
   endtask

   task automatic write_word(input string name, input soc_pkg::soc_addr_t addr,
                             input soc_pkg::soc_data_t data);
      soc_pkg::soc_byte_t rsp;
      logic got;
      send_byte(`SOC_CMD_WRITE);
      send_byte(addr);
      for (int i = 0; i < 4; i++) begin
         send_byte(data[8*i +: 8]);
      end
      recv_byte(name, rsp, got);
      if (got) begin
         check_word(name, 32'(`SOC_RSP_ACK), 32'(rsp));
      end
   endtask

   task automatic read_check(input string name, input soc_pkg::soc_addr_t addr,
                             input soc_pkg::soc_data_t expected);
      soc_pkg::soc_byte_t b;
      soc_pkg::soc_data_t data;
      logic got;
      logic ok;
      data = '0;
      ok = 1'b1;
      send_byte(`SOC_CMD_READ);
      send_byte(addr);
      // four bytes back, lsb first
      for (int i = 0; i < 4 && ok; i++) begin
         recv_byte(name, b, got);
         ok = got;
         data[8*i +: 8] = b;
      end
      if (ok) begin
         check_word(name, expected, data);
      end
   endtask

   task automatic wait_silence(input string name, input int cycles);
      logic quiet;
      quiet = 1'b1;
      repeat (cycles) begin
         @(negedge clk_i);
         if (txd_o !== 1'b1) begin
            quiet = 1'b0;
         end
      end
      assert (quiet) else begin
         $display("%s: txd_o was active after an unknown command byte", name);
         test_errs++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      total_errs += test_errs;
      if (test_errs == 0) begin
         $display("%s: pass", name);
      end else begin
         tests_failed++;
         $display("%s: fail, %0d errors", name, test_errs);
      end
      test_errs = 0;
   endtask

   initial begin
      soc_pkg::soc_addr_t addr;
      soc_pkg::soc_data_t data;
      soc_pkg::soc_byte_t junk;
      logic [31:0] r;
      clk_i = 1'b0;
      reset_i = 1'b1;
      rxd_i = 1'b1;
      seed = 32'h1a70fba3;
      cycle_cnt = 0;
      test_errs = 0;
      total_errs = 0;
      tests_run = 0;
      tests_failed = 0;
      trap_model = 1'b0;
      for (int i = 0; i < 64; i++) begin
         mem_model[6'(i)] = '0;
         mem_valid[6'(i)] = 1'b0;
      end
      repeat (8) @(negedge clk_i);
      reset_i = 1'b0;
      repeat (`SOC_RST_HOLD + 4) @(negedge clk_i);

      check_word("reset_state", 32'd0, 32'(trap_o));
      check_word("reset_state", 32'd1, 32'(txd_o));
      read_check("reset_state", 8'(`SOC_TRAP_ADDR), 32'd0);
      finish_test("reset_state");

      repeat (100) begin
         r = $random(seed);
         addr = {2'b00, r[5:0]};
         data = $random(seed);
         write_word("ram_random", addr, data);
         mem_model[addr[5:0]] = data;
         mem_valid[addr[5:0]] = 1'b1;
      end
      for (int i = 0; i < 64; i++) begin
         if (mem_valid[6'(i)]) begin
            read_check("ram_random", 8'(i), mem_model[6'(i)]);
         end
      end
      finish_test("ram_random");

      // both ends of the hole, then random addresses inside it
      for (int i = 0; i < 20; i++) begin
         r = $random(seed);
         if (i == 0) begin
            addr = 8'd64;
         end else if (i == 1) begin
            addr = 8'd254;
         end else begin
            addr = 8'(64 + r[15:0] % 191);
         end
         data = $random(seed);
         write_word("unmapped", addr, data);
         read_check("unmapped", addr, 32'd0);
      end
      finish_test("unmapped");

      write_word("trap_control", 8'(`SOC_TRAP_ADDR), 32'd1);
      trap_model = 1'b1;
      check_word("trap_control", 32'(trap_model), 32'(trap_o));
      read_check("trap_control", 8'(`SOC_TRAP_ADDR), 32'(trap_model));
      write_word("trap_control", 8'(`SOC_TRAP_ADDR), 32'd0);
      trap_model = 1'b0;
      check_word("trap_control", 32'(trap_model), 32'(trap_o));
      read_check("trap_control", 8'(`SOC_TRAP_ADDR), 32'(trap_model));
      finish_test("trap_control");

      r = $random(seed);
      junk = r[7:0];
      while (junk == `SOC_CMD_WRITE || junk == `SOC_CMD_READ) begin
         r = $random(seed);
         junk = r[7:0];
      end
      send_byte(junk);
      wait_silence("bad_command", 20 * BYTE_CYCLES);
      addr = 8'd0;
      for (int i = 0; i < 64; i++) begin
         if (mem_valid[6'(i)]) begin
            addr = 8'(i);
         end
      end
      read_check("bad_command", addr, mem_model[addr[5:0]]);
      finish_test("bad_command");

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
      if (total_errs == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/soc_pkg.sv
hw/reset_pulse_gen.sv
hw/uart_core.sv
hw/uart_wb_bridge.sv
hw/soc_mem.sv
hw/soc_top.sv
verif/tb_soc_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_soc_top
RTL_TOP ?= soc_top
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
INC_DIR ?= hw
RTL_SRCS ?= hw/soc_pkg.sv hw/reset_pulse_gen.sv hw/uart_core.sv \
            hw/uart_wb_bridge.sv hw/soc_mem.sv hw/soc_top.sv
VFLAGS ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only +incdir+$(INC_DIR) $(RTL_SRCS) --top-module $(RTL_TOP) $(VFLAGS)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) $(VFLAGS)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
